// ==== logic/dma_pkt_pkg.sv ====
// Constants of the DMA packet channels, as seen from the card side.
// Control codes cover only the downstream acks and data words.
// Field positions assume the first request word layout of the DMA engine.

`default_nettype none

package dma_pkt_pkg;

  //********************************************************************
  // channel widths
  //********************************************************************
  parameter int DMA_DATA_W = 64;
  parameter int DMA_CTRL_W = 8;
  parameter int KEEP_W     = 8;   // one bit per data byte

  //********************************************************************
  // request word decode
  //********************************************************************
  // a first request word has the request bit set and the continue bit clear
  parameter int CTRL_REQ_BIT  = 4;
  parameter int CTRL_CONT_BIT = 3;

  parameter int TAG_LSB = 36;     // tag sits at 39:36
  parameter int TAG_W   = 4;
  parameter int LEN_W   = 16;     // length at 15:0

  //********************************************************************
  // reply words
  //********************************************************************
  parameter int ACK_TAG_LSB = 4;  // tag goes to 7:4 of the first ack

  parameter logic [DMA_CTRL_W-1:0] CTRL_ACK_TAG = 8'h01;
  parameter logic [DMA_CTRL_W-1:0] CTRL_ACK_LEN = 8'h20;
  parameter logic [DMA_CTRL_W-1:0] CTRL_DATA    = 8'h0C;  // both halves valid

  // last beat codes
  parameter logic [DMA_CTRL_W-1:0] CTRL_LAST_LO = 8'h14;  // low half only
  parameter logic [DMA_CTRL_W-1:0] CTRL_LAST_HI = 8'h1C;  // upper half in use

  // tkeep at or below this means the upper four bytes are empty
  parameter logic [KEEP_W-1:0] KEEP_LO_MAX = 8'h0F;

endpackage

`default_nettype wire

// ==== logic/bridge_ctrl_pkg.sv ====
// Control encodings shared between the transfer FSM and the reply path.
// Encodings are plain binary and carry no meaning outside the bridge.

`default_nettype none

package bridge_ctrl_pkg;

  // transfer sequence, one request at a time
  typedef enum logic [2:0] {
    IDLE,      // waiting for a queued request
    POP,       // take the head of the queue
    ACK_TAG,   // first ack word on the from-host channel
    ACK_LEN,   // second ack word
    DATA       // stream beats pass through until tlast
  } xfer_state_t;

  // which word the reply path puts on the from-host channel
  typedef enum logic [1:0] {
    REPLY_NONE,
    REPLY_TAG,
    REPLY_LEN,
    REPLY_DATA
  } reply_sel_t;

endpackage

`default_nettype wire

// ==== logic/req_queue.sv ====
// Queue of first request words taken from the DMA to-host channel.
// REQ_DEPTH must be a power of two, at least 4.
// The sender must honour almost_full; a request that finds the queue full
// is lost.

`timescale 1ns/1ps
`default_nettype none

module req_queue #(
  parameter int REQ_DEPTH = 8
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire  [dma_pkt_pkg::DMA_DATA_W-1:0] tohost_data,
  input  wire  [dma_pkt_pkg::DMA_CTRL_W-1:0] tohost_ctrl,
  input  wire                                tohost_valid,
  input  wire                                q_pop,
  output logic [dma_pkt_pkg::DMA_DATA_W-1:0] q_head,
  output logic                               q_empty,
  output logic                               almost_full
);

  import dma_pkt_pkg::*;

  localparam int PTR_W = $clog2(REQ_DEPTH);
  localparam int CNT_W = PTR_W + 1;   // count must reach REQ_DEPTH

  logic [DMA_DATA_W-1:0] mem [REQ_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;

  logic first_req;
  logic full;
  logic push;
  logic pop;

  //********************************************************************
  // request decode
  //********************************************************************
  // only the first word of a request is kept, the rest is host info
  assign first_req = tohost_valid & tohost_ctrl[CTRL_REQ_BIT] & ~tohost_ctrl[CTRL_CONT_BIT];

  assign full    = (count == CNT_W'(REQ_DEPTH));
  assign q_empty = (count == '0);
  assign push    = first_req & ~full;
  assign pop     = q_pop & ~q_empty;

  //********************************************************************
  // storage
  //********************************************************************
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= tohost_data;
    end
  end

  assign q_head = mem[rd_ptr];   // oldest entry

  //********************************************************************
  // pointers, count and almost_full
  //********************************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      almost_full <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // idle or push and pop together
      endcase

      // one edge behind the count
      almost_full <= (count >= CNT_W'(REQ_DEPTH - 1));
    end
  end

endmodule

`default_nettype wire

// ==== logic/reply_path.sv ====
// Output side of the bridge: ack words and the stream pass-through.
// In the data phase the from-host channel follows the stream with no
// register, so the stream source must hold its beat while accept is low.

`timescale 1ns/1ps
`default_nettype none

module reply_path (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire  [dma_pkt_pkg::DMA_DATA_W-1:0] q_head,
  input  wire                                fields_load,
  input  wire  bridge_ctrl_pkg::reply_sel_t  reply_sel,
  input  wire                                fromhost_accept,
  input  wire                                s_tvalid,
  input  wire  [dma_pkt_pkg::DMA_DATA_W-1:0] s_tdata,
  input  wire  [dma_pkt_pkg::KEEP_W-1:0]     s_tkeep,
  input  wire                                s_tlast,
  output logic                               s_tready,
  output logic [dma_pkt_pkg::DMA_DATA_W-1:0] fromhost_data,
  output logic [dma_pkt_pkg::DMA_CTRL_W-1:0] fromhost_ctrl,
  output logic                               fromhost_valid,
  output logic                               beat_last
);

  import dma_pkt_pkg::*;
  import bridge_ctrl_pkg::*;

  logic [TAG_W-1:0]      tag_q;
  logic [LEN_W-1:0]      len_q;
  logic                  data_phase;
  logic [DMA_CTRL_W-1:0] last_ctrl;

  // request fields, held for the whole transfer
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tag_q <= '0;
      len_q <= '0;
    end
    else if (fields_load)
    begin
      tag_q <= q_head[TAG_LSB +: TAG_W];
      len_q <= q_head[LEN_W-1:0];
    end
  end

  //********************************************************************
  // stream handshake
  //********************************************************************
  assign data_phase = (reply_sel == REPLY_DATA);
  assign s_tready   = data_phase & fromhost_accept;       // host stalls the stream
  assign beat_last  = s_tvalid & s_tready & s_tlast;

  // upper half empty when no keep bit above byte 3
  assign last_ctrl = (s_tkeep <= KEEP_LO_MAX) ? CTRL_LAST_LO : CTRL_LAST_HI;

  //********************************************************************
  // from-host word select
  //********************************************************************
  always_comb
  begin
    fromhost_data  = '0;
    fromhost_ctrl  = '0;
    fromhost_valid = 1'b0;
    case (reply_sel)
      REPLY_TAG:
      begin
        fromhost_data[ACK_TAG_LSB +: TAG_W] = tag_q;
        fromhost_ctrl  = CTRL_ACK_TAG;
        fromhost_valid = 1'b1;
      end
      REPLY_LEN:
      begin
        fromhost_data[LEN_W-1:0] = len_q;
        fromhost_ctrl  = CTRL_ACK_LEN;
        fromhost_valid = 1'b1;
      end
      REPLY_DATA:
      begin
        fromhost_data  = s_tdata;
        fromhost_ctrl  = s_tlast ? last_ctrl : CTRL_DATA;
        fromhost_valid = s_tvalid;
      end
      default: ;   // nothing on the channel
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/xfer_ctrl.sv ====
// Sequencer for one downstream transfer: pop, tag ack, length ack, data.
// Requests are served strictly in queue order, one at a time.
// The data phase ends only on a beat with tlast.

`timescale 1ns/1ps
`default_nettype none

module xfer_ctrl (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         q_empty,
  input  wire                         fromhost_accept,
  input  wire                         beat_last,
  output logic                        q_pop,
  output logic                        fields_load,
  output bridge_ctrl_pkg::reply_sel_t reply_sel
);

  import bridge_ctrl_pkg::*;

  xfer_state_t state_q;
  xfer_state_t state_d;

  //********************************************************************
  // next state
  //********************************************************************
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (!q_empty)
          state_d = POP;
      end
      POP:
      begin
        state_d = ACK_TAG;   // fields are loaded on this edge
      end
      ACK_TAG:
      begin
        // ack held until the host takes it
        if (fromhost_accept)
          state_d = ACK_LEN;
      end
      ACK_LEN:
      begin
        if (fromhost_accept)
          state_d = DATA;
      end
      DATA:
      begin
        if (beat_last)
          state_d = IDLE;
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  //********************************************************************
  // outputs
  //********************************************************************
  // POP is only entered from IDLE with the queue non-empty
  assign q_pop       = (state_q == POP);
  assign fields_load = (state_q == POP);   // same cycle as the pop

  always_comb
  begin
    case (state_q)
      ACK_TAG: reply_sel = REPLY_TAG;
      ACK_LEN: reply_sel = REPLY_LEN;
      DATA:    reply_sel = REPLY_DATA;
      default: reply_sel = REPLY_NONE;   // idle and pop
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/dma_stream_bridge.sv ====
// Downstream bridge between the DMA packet channels and an AXI-stream source.
// The to-host channel has no per-word accept; the sender watches almost_full.
// During data, s_tready and the from-host word follow the host with no delay.

`timescale 1ns/1ps
`default_nettype none

module dma_stream_bridge #(
  parameter int REQ_DEPTH = 8   // request queue depth, power of two
) (
  input  wire                                clk,
  input  wire                                rst_n,

  // DMA to-host channel, request words
  input  wire  [dma_pkt_pkg::DMA_DATA_W-1:0] tohost_data,
  input  wire  [dma_pkt_pkg::DMA_CTRL_W-1:0] tohost_ctrl,
  input  wire                                tohost_valid,
  output logic                               tohost_almost_full,

  // DMA from-host channel, acks and data
  output logic [dma_pkt_pkg::DMA_DATA_W-1:0] fromhost_data,
  output logic [dma_pkt_pkg::DMA_CTRL_W-1:0] fromhost_ctrl,
  output logic                               fromhost_valid,
  input  wire                                fromhost_accept,

  // card side stream
  input  wire                                s_tvalid,
  output logic                               s_tready,
  input  wire  [dma_pkt_pkg::DMA_DATA_W-1:0] s_tdata,
  input  wire  [dma_pkt_pkg::KEEP_W-1:0]     s_tkeep,
  input  wire                                s_tlast
);

  logic [dma_pkt_pkg::DMA_DATA_W-1:0] q_head;
  logic                               q_empty;
  logic                               q_pop;
  logic                               fields_load;
  logic                               beat_last;
  bridge_ctrl_pkg::reply_sel_t        reply_sel;

  req_queue #(
    .REQ_DEPTH (REQ_DEPTH)
  ) u_req_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .tohost_data  (tohost_data),
    .tohost_ctrl  (tohost_ctrl),
    .tohost_valid (tohost_valid),
    .q_pop        (q_pop),
    .q_head       (q_head),
    .q_empty      (q_empty),
    .almost_full  (tohost_almost_full)
  );

  xfer_ctrl u_xfer_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .q_empty         (q_empty),
    .fromhost_accept (fromhost_accept),
    .beat_last       (beat_last),
    .q_pop           (q_pop),
    .fields_load     (fields_load),
    .reply_sel       (reply_sel)
  );

  reply_path u_reply_path (
    .clk             (clk),
    .rst_n           (rst_n),
    .q_head          (q_head),
    .fields_load     (fields_load),
    .reply_sel       (reply_sel),
    .fromhost_accept (fromhost_accept),
    .s_tvalid        (s_tvalid),
    .s_tdata         (s_tdata),
    .s_tkeep         (s_tkeep),
    .s_tlast         (s_tlast),
    .s_tready        (s_tready),
    .fromhost_data   (fromhost_data),
    .fromhost_ctrl   (fromhost_ctrl),
    .fromhost_valid  (fromhost_valid),
    .beat_last       (beat_last)
  );

endmodule

`default_nettype wire

// ==== bench/tb_bridge.sv ====
// Testbench for the downstream DMA bridge, queue depth 8.
// Host accept and stream valid can be randomized; beats are held until taken.
// Expected from-host words are queued before the DUT can produce them.

`timescale 1ns/1ps
`default_nettype none

module tb_bridge;

  import dma_pkt_pkg::*;

  localparam int  DEPTH         = 8;
  localparam time CLK_PERIOD    = 40ns;
  // beats of all transfers in the tests below
  localparam int  PLANNED_BEATS = (5 + 3) + (2 + 3 + 4) + 4 * 6 + 3 + 2 + (DEPTH - 1) * 2;
  localparam time RUN_LIMIT     = (PLANNED_BEATS * 20 + 300) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [63:0] tohost_data;
  logic [7:0]  tohost_ctrl;
  logic        tohost_valid;
  wire         tohost_almost_full;
  wire  [63:0] fromhost_data;
  wire  [7:0]  fromhost_ctrl;
  wire         fromhost_valid;
  logic        fromhost_accept;
  logic        s_tvalid;
  wire         s_tready;
  logic [63:0] s_tdata;
  logic [7:0]  s_tkeep;
  logic        s_tlast;

  logic [71:0] exp_word_q[$];   // {ctrl, data}
  int          exp_kind_q[$];   // 0 tag ack, 1 length ack, 2 data
  logic [63:0] beat_data_q[$];
  logic [7:0]  beat_keep_q[$];
  logic        beat_last_q[$];

  logic bp_on     = 1'b0;
  logic stream_en = 1'b0;
  logic in_data   = 1'b0;
  int   errors    = 0;
  int   checks    = 0;
  int   tests     = 0;
  int   done_xfers = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dma_stream_bridge #(.REQ_DEPTH(DEPTH)) dut0 (
    .clk(clk), .rst_n(rst_n),
    .tohost_data(tohost_data), .tohost_ctrl(tohost_ctrl),
    .tohost_valid(tohost_valid), .tohost_almost_full(tohost_almost_full),
    .fromhost_data(fromhost_data), .fromhost_ctrl(fromhost_ctrl),
    .fromhost_valid(fromhost_valid), .fromhost_accept(fromhost_accept),
    .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
    .s_tkeep(s_tkeep), .s_tlast(s_tlast)
  );

  //**********************************************************************
  // reference model
  //**********************************************************************
  function automatic logic [71:0] ref_word(input int kind, input logic [3:0] tag,
                                           input logic [15:0] len, input logic [63:0] data,
                                           input logic [7:0] keep, input logic last);
    logic [63:0] d;
    logic [7:0]  c;
    d = '0;
    c = '0;
    case (kind)
      0:
      begin
        d[ACK_TAG_LSB +: 4] = tag;
        c = 8'h01;
      end
      1:
      begin
        d[15:0] = len;
        c = 8'h20;
      end
      default:
      begin
        d = data;
        if (!last)
          c = 8'h0C;
        else
          c = (keep <= 8'h0F) ? 8'h14 : 8'h1C;   // upper half empty or not
      end
    endcase
    return {c, d};
  endfunction

  // queue the acks and beats of one transfer
  task automatic plan_xfer(input logic [3:0] tag, input logic [15:0] len,
                           input int nbeats, input logic hi_last);
    logic [63:0] d;
    logic [7:0]  k;
    logic        l;
    exp_word_q.push_back(ref_word(0, tag, len, '0, '0, 1'b0));
    exp_kind_q.push_back(0);
    exp_word_q.push_back(ref_word(1, tag, len, '0, '0, 1'b0));
    exp_kind_q.push_back(1);
    for (int i = 0; i < nbeats; i++)
    begin
      d = {$urandom, $urandom};
      l = (i == nbeats - 1);
      k = 8'hFF;
      if (l)
        k = hi_last ? (8'hFF >> ($urandom % 4)) : (8'h0F >> ($urandom % 4));
      beat_data_q.push_back(d);
      beat_keep_q.push_back(k);
      beat_last_q.push_back(l);
      exp_word_q.push_back(ref_word(2, tag, len, d, k, l));
      exp_kind_q.push_back(2);
    end
  endtask

  //**********************************************************************
  // drivers
  //**********************************************************************
  task automatic send_word(input logic [7:0] ctrl, input logic [3:0] tag,
                           input logic [15:0] len);
    @(posedge clk);
    tohost_valid <= 1'b1;
    tohost_ctrl  <= ctrl;
    tohost_data  <= {24'($urandom), tag, 20'($urandom), len};
  endtask

  task automatic end_send();
    @(posedge clk);
    tohost_valid <= 1'b0;
    tohost_ctrl  <= '0;
  endtask

  // host accept and stream source, beats held until they move
  always @(posedge clk)
  begin : stream_drive
    logic moved;
    moved = s_tvalid && s_tready;
    if (moved)
    begin
      beat_data_q.delete(0);
      beat_keep_q.delete(0);
      beat_last_q.delete(0);
    end
    fromhost_accept <= bp_on ? 1'($urandom % 2) : 1'b1;
    if (moved || !s_tvalid)
    begin
      if (stream_en && beat_data_q.size() > 0 && (!bp_on || ($urandom % 2) == 1))
      begin
        s_tvalid <= 1'b1;
        s_tdata  <= beat_data_q[0];
        s_tkeep  <= beat_keep_q[0];
        s_tlast  <= beat_last_q[0];
      end
      else
        s_tvalid <= 1'b0;
    end
  end

  //**********************************************************************
  // compare
  //**********************************************************************
  always @(posedge clk)
  begin : compare
    logic [71:0] w;
    int          kind;
    if (in_data)
    begin
      checks++;
      assert (s_tready == fromhost_accept) else
      begin
        $display("Fail t=%0t s_tready expected %b got %b", $time, fromhost_accept, s_tready);
        errors++;
      end
      checks++;
      assert (fromhost_valid == s_tvalid) else
      begin
        $display("Fail t=%0t fromhost_valid expected %b got %b", $time, s_tvalid,
                 fromhost_valid);
        errors++;
      end
    end
    if (fromhost_valid && fromhost_accept)
    begin
      if (exp_word_q.size() == 0)
      begin
        $display("t=%0t from-host word %h came out with none expected", $time, fromhost_data);
        errors++;
      end
      else
      begin
        w    = exp_word_q.pop_front();
        kind = exp_kind_q.pop_front();
        checks++;
        assert (fromhost_data == w[63:0]) else
        begin
          $display("Fail t=%0t fromhost_data expected %h got %h", $time, w[63:0], fromhost_data);
          errors++;
        end
        checks++;
        assert (fromhost_ctrl == w[71:64]) else
        begin
          $display("Fail t=%0t fromhost_ctrl expected %h got %h", $time, w[71:64], fromhost_ctrl);
          errors++;
        end
        if (kind == 1)
          in_data = 1'b1;
        else if (kind == 2 && (w[71:64] == 8'h14 || w[71:64] == 8'h1C))
        begin
          in_data = 1'b0;
          done_xfers++;
        end
      end
    end
  end

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_word_q.size() > 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_word_q.size() > 0)
    begin
      $display("t=%0t %0d expected words never came out", $time, exp_word_q.size());
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_before);
  endtask

  // watchdog
  initial
  begin
    #(RUN_LIMIT);
    $display("watchdog expired, the run hung");
    $display("Checks failed");
    $finish;
  end

  //**********************************************************************
  // tests
  //**********************************************************************
  initial
  begin : main
    int e;
    int n;
    int xfers_before;
    void'($urandom(21326));
    rst_n = 1'b0;
    tohost_valid = 1'b0;
    tohost_ctrl = '0;
    tohost_data = '0;
    fromhost_accept = 1'b0;
    s_tvalid = 1'b0;
    s_tdata = '0;
    s_tkeep = '0;
    s_tlast = 1'b0;

    // reset state
    e = errors;
    for (int i = 0; i < 5; i++)
    begin
      @(posedge clk);
      if (i == 3)
        rst_n <= 1'b1;
      #1;
      checks++;
      assert (!fromhost_valid && !s_tready && !tohost_almost_full) else
      begin
        $display("Fail t=%0t fromhost_valid/s_tready/tohost_almost_full expected 000 got %b%b%b",
                 $time, fromhost_valid, s_tready, tohost_almost_full);
        errors++;
      end
    end
    finish_test("reset state", e);

    // single requests, both last-beat codes
    e = errors;
    stream_en = 1'b1;
    plan_xfer(4'h3, 16'd40, 5, 1'b0);
    send_word(8'h10, 4'h3, 16'd40);
    end_send();
    wait_drain(200);
    plan_xfer(4'hA, 16'd24, 3, 1'b1);
    send_word(8'h10, 4'hA, 16'd24);
    end_send();
    wait_drain(200);
    finish_test("single request", e);

    // queued requests, sent before any stream data
    e = errors;
    stream_en = 1'b0;
    for (int i = 0; i < 3; i++)
      plan_xfer(4'(i + 5), 16'(8 * (i + 2)), i + 2, 1'($urandom % 2));
    for (int i = 0; i < 3; i++)
      send_word(8'h10, 4'(i + 5), 16'(8 * (i + 2)));
    end_send();
    stream_en = 1'b1;
    wait_drain(300);
    finish_test("queued requests", e);

    // back-pressure on both sides
    e = errors;
    bp_on = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      plan_xfer(4'(i), 16'($urandom), 6, 1'($urandom % 2));
      send_word(8'h10, 4'(i), exp_word_q[exp_word_q.size() - 7][15:0]);
      end_send();
    end
    wait_drain(1000);
    bp_on = 1'b0;
    finish_test("back-pressure", e);

    // continuation and non-request words must be dropped
    e = errors;
    send_word(8'h18, 4'h1, 16'd8);
    send_word(8'h08, 4'h2, 16'd8);
    send_word(8'h00, 4'h3, 16'd8);
    end_send();
    repeat (20) @(posedge clk);
    plan_xfer(4'hC, 16'd16, 3, 1'b1);   // a real request still works
    send_word(8'h10, 4'hC, 16'd16);
    end_send();
    wait_drain(200);
    finish_test("non-request words", e);

    // almost_full with one transfer stalled in the data phase
    e = errors;
    stream_en = 1'b0;
    plan_xfer(4'h7, 16'd16, 2, 1'b0);
    send_word(8'h10, 4'h7, 16'd16);
    end_send();
    n = 0;
    while (!in_data && n < 100)
    begin
      @(posedge clk);
      n++;
    end
    for (int i = 0; i < DEPTH - 1; i++)
      plan_xfer(4'(i + 8), 16'd16, 2, 1'($urandom % 2));
    for (int i = 0; i < DEPTH - 1; i++)
      send_word(8'h10, 4'(i + 8), 16'd16);
    end_send();
    @(posedge clk);
    #1;
    checks++;
    assert (tohost_almost_full) else
    begin
      $display("Fail t=%0t tohost_almost_full expected 1 got %b", $time, tohost_almost_full);
      errors++;
    end
    xfers_before = done_xfers;
    stream_en = 1'b1;
    n = 0;
    while (tohost_almost_full && n < 200)
    begin
      @(posedge clk);
      n++;
    end
    checks++;
    assert (!tohost_almost_full && done_xfers > xfers_before) else
    begin
      $display("t=%0t almost_full did not fall after a finished transfer", $time);
      errors++;
    end
    wait_drain(500);
    finish_test("almost-full", e);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/dma_pkt_pkg.sv
logic/bridge_ctrl_pkg.sv
logic/req_queue.sv
logic/reply_path.sv
logic/xfer_ctrl.sv
logic/dma_stream_bridge.sv
bench/tb_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator.
# The result is taken from the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_bridge \
  -o tb_bridge_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_bridge_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
